// ==== rtl/odma_defines.svh ====
// Local write port parameters
`ifndef ODMA_DEFINES_SVH
`define ODMA_DEFINES_SVH

// Shared write channel widths
`define ODMA_EA_WIDTH 64
`define ODMA_DATA_WIDTH 1024
`define ODMA_BE_WIDTH (`ODMA_DATA_WIDTH / 8)

// AXI ID width, the low field of the ID names the engine
`define ODMA_AXI_ID_WIDTH 5
`define ODMA_ENGINE_ID_BITS 3

// Engine ID values carried in the low ID field
`define ODMA_CMP_ENGINE_ID 5
`define ODMA_A2HMM_ENGINE_ID 0
`define ODMA_A2HST_ENGINE_ID 1

`endif

// ==== rtl/odma_wr_pkg.sv ====
// Local write arbiter types
`include "odma_defines.svh"

package odma_wr_pkg;

    typedef logic [`ODMA_EA_WIDTH-1:0] ea_t;
    typedef logic [`ODMA_DATA_WIDTH-1:0] data_t;
    typedef logic [`ODMA_BE_WIDTH-1:0] be_t;
    typedef logic [`ODMA_AXI_ID_WIDTH-1:0] axi_id_t;

    // One ready bit for every possible AXI ID value
    typedef logic [(2**`ODMA_AXI_ID_WIDTH)-1:0] rsp_ready_vec_t;

    // Owner of the shared write channel
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_CMP,
        GRANT_MM,
        GRANT_ST
    } grant_state_t;

endpackage

// ==== rtl/odma_wr_grant_arbiter.sv ====
// Write request grant arbiter
`timescale 1ns/1ps

module odma_wr_grant_arbiter (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      cmp_valid,
    input  logic                      mm_valid,
    input  logic                      st_valid,
    input  logic                      cmp_last,
    input  logic                      mm_last,
    input  logic                      st_last,
    input  logic                      lcl_wr_ready,
    output odma_wr_pkg::grant_state_t grant
);

    logic                      gnt_valid;
    logic                      gnt_last;
    logic                      others_valid;
    logic                      any_valid;
    logic                      pkt_end;
    logic                      linger;
    odma_wr_pkg::grant_state_t grant_nxt;

    // Request state of the engine currently holding the channel
    always_comb begin
        case (grant)
            odma_wr_pkg::GRANT_CMP: begin
                gnt_valid    = cmp_valid;
                gnt_last     = cmp_last;
                others_valid = mm_valid | st_valid;
            end
            odma_wr_pkg::GRANT_MM: begin
                gnt_valid    = mm_valid;
                gnt_last     = mm_last;
                others_valid = cmp_valid | st_valid;
            end
            odma_wr_pkg::GRANT_ST: begin
                gnt_valid    = st_valid;
                gnt_last     = st_last;
                others_valid = cmp_valid | mm_valid;
            end
            default: begin
                gnt_valid    = 1'b0;
                gnt_last     = 1'b0;
                others_valid = 1'b0;
            end
        endcase
    end

    assign any_valid = cmp_valid | mm_valid | st_valid;
    assign pkt_end   = gnt_valid & gnt_last & lcl_wr_ready;

    always_comb begin
        grant_nxt = grant;
        if (grant == odma_wr_pkg::GRANT_NONE) begin
            if (cmp_valid)
                grant_nxt = odma_wr_pkg::GRANT_CMP;
            else if (mm_valid)
                grant_nxt = odma_wr_pkg::GRANT_MM;
            else if (st_valid)
                grant_nxt = odma_wr_pkg::GRANT_ST;
        end else if (pkt_end) begin
            // Hand over to one of the other two engines
            case (grant)
                odma_wr_pkg::GRANT_CMP:
                    if (mm_valid)
                        grant_nxt = odma_wr_pkg::GRANT_MM;
                    else if (st_valid)
                        grant_nxt = odma_wr_pkg::GRANT_ST;
                odma_wr_pkg::GRANT_MM:
                    if (cmp_valid)
                        grant_nxt = odma_wr_pkg::GRANT_CMP;
                    else if (st_valid)
                        grant_nxt = odma_wr_pkg::GRANT_ST;
                default:
                    if (cmp_valid)
                        grant_nxt = odma_wr_pkg::GRANT_CMP;
                    else if (mm_valid)
                        grant_nxt = odma_wr_pkg::GRANT_MM;
            endcase
        end else if (linger && !gnt_valid) begin
            // Current owner comes first, so only move while it is idle
            if (cmp_valid)
                grant_nxt = odma_wr_pkg::GRANT_CMP;
            else if (mm_valid)
                grant_nxt = odma_wr_pkg::GRANT_MM;
            else if (st_valid)
                grant_nxt = odma_wr_pkg::GRANT_ST;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            grant  <= odma_wr_pkg::GRANT_NONE;
            linger <= 1'b0;
        end else begin
            grant <= grant_nxt;
            if (pkt_end && !others_valid)
                linger <= 1'b1;
            else if (linger && any_valid)
                linger <= 1'b0;
        end
    end

    function automatic logic engine_valid(input odma_wr_pkg::grant_state_t g,
                                          input logic [2:0] v);
        case (g)
            odma_wr_pkg::GRANT_CMP: engine_valid = v[0];
            odma_wr_pkg::GRANT_MM:  engine_valid = v[1];
            odma_wr_pkg::GRANT_ST:  engine_valid = v[2];
            default:                engine_valid = 1'b0;
        endcase
    endfunction

    // Packet lock holds until the last beat transfers
    a_packet_lock: assert property (@(posedge clk) disable iff (!resetn)
        (grant != odma_wr_pkg::GRANT_NONE) && gnt_valid && !pkt_end && !linger
        |=> $stable(grant));

    a_grant_to_valid: assert property (@(posedge clk) disable iff (!resetn)
        $changed(grant) |-> engine_valid(grant, $past({st_valid, mm_valid, cmp_valid})));

endmodule

// ==== rtl/odma_wr_req_mux.sv ====
// Write request channel multiplexer
`timescale 1ns/1ps

module odma_wr_req_mux (
    input  odma_wr_pkg::grant_state_t grant,
    input  logic                      cmp_wr_valid,
    input  logic                      cmp_wr_first,
    input  logic                      cmp_wr_last,
    input  odma_wr_pkg::ea_t          cmp_wr_ea,
    input  odma_wr_pkg::axi_id_t      cmp_wr_axi_id,
    input  odma_wr_pkg::be_t          cmp_wr_be,
    input  odma_wr_pkg::data_t        cmp_wr_data,
    input  logic                      mm_wr_valid,
    input  logic                      mm_wr_first,
    input  logic                      mm_wr_last,
    input  odma_wr_pkg::ea_t          mm_wr_ea,
    input  odma_wr_pkg::axi_id_t      mm_wr_axi_id,
    input  odma_wr_pkg::be_t          mm_wr_be,
    input  odma_wr_pkg::data_t        mm_wr_data,
    input  logic                      st_wr_valid,
    input  logic                      st_wr_first,
    input  logic                      st_wr_last,
    input  odma_wr_pkg::ea_t          st_wr_ea,
    input  odma_wr_pkg::axi_id_t      st_wr_axi_id,
    input  odma_wr_pkg::be_t          st_wr_be,
    input  odma_wr_pkg::data_t        st_wr_data,
    input  logic                      lcl_wr_ready,
    output logic                      lcl_wr_valid,
    output odma_wr_pkg::ea_t          lcl_wr_ea,
    output odma_wr_pkg::axi_id_t      lcl_wr_axi_id,
    output odma_wr_pkg::be_t          lcl_wr_be,
    output logic                      lcl_wr_first,
    output logic                      lcl_wr_last,
    output odma_wr_pkg::data_t        lcl_wr_data,
    output logic                      cmp_wr_ready,
    output logic                      mm_wr_ready,
    output logic                      st_wr_ready
);

    // Beat of the granted engine, all zero while nobody owns the channel
    always_comb begin
        case (grant)
            odma_wr_pkg::GRANT_CMP: begin
                lcl_wr_valid  = cmp_wr_valid;
                lcl_wr_ea     = cmp_wr_ea;
                lcl_wr_axi_id = cmp_wr_axi_id;
                lcl_wr_be     = cmp_wr_be;
                lcl_wr_first  = cmp_wr_first;
                lcl_wr_last   = cmp_wr_last;
                lcl_wr_data   = cmp_wr_data;
            end
            odma_wr_pkg::GRANT_MM: begin
                lcl_wr_valid  = mm_wr_valid;
                lcl_wr_ea     = mm_wr_ea;
                lcl_wr_axi_id = mm_wr_axi_id;
                lcl_wr_be     = mm_wr_be;
                lcl_wr_first  = mm_wr_first;
                lcl_wr_last   = mm_wr_last;
                lcl_wr_data   = mm_wr_data;
            end
            odma_wr_pkg::GRANT_ST: begin
                lcl_wr_valid  = st_wr_valid;
                lcl_wr_ea     = st_wr_ea;
                lcl_wr_axi_id = st_wr_axi_id;
                lcl_wr_be     = st_wr_be;
                lcl_wr_first  = st_wr_first;
                lcl_wr_last   = st_wr_last;
                lcl_wr_data   = st_wr_data;
            end
            default: begin
                lcl_wr_valid  = 1'b0;
                lcl_wr_ea     = '0;
                lcl_wr_axi_id = '0;
                lcl_wr_be     = '0;
                lcl_wr_first  = 1'b0;
                lcl_wr_last   = 1'b0;
                lcl_wr_data   = '0;
            end
        endcase
    end

    // Shared ready reaches the owner only
    assign cmp_wr_ready = lcl_wr_ready & (grant == odma_wr_pkg::GRANT_CMP);
    assign mm_wr_ready  = lcl_wr_ready & (grant == odma_wr_pkg::GRANT_MM);
    assign st_wr_ready  = lcl_wr_ready & (grant == odma_wr_pkg::GRANT_ST);

endmodule

// ==== rtl/odma_wr_rsp_dispatch.sv ====
// Write response dispatcher
`timescale 1ns/1ps
`include "odma_defines.svh"

module odma_wr_rsp_dispatch (
    input  logic                        lcl_wr_rsp_valid,
    input  odma_wr_pkg::axi_id_t        lcl_wr_rsp_axi_id,
    input  logic                        lcl_wr_rsp_code,
    output odma_wr_pkg::rsp_ready_vec_t lcl_wr_rsp_ready,
    output logic                        cmp_rsp_valid,
    output odma_wr_pkg::axi_id_t        cmp_rsp_axi_id,
    output logic                        cmp_rsp_code,
    input  logic                        cmp_rsp_ready,
    output logic                        mm_rsp_valid,
    output odma_wr_pkg::axi_id_t        mm_rsp_axi_id,
    output logic                        mm_rsp_code,
    input  logic                        mm_rsp_ready,
    output logic                        st_rsp_valid,
    output odma_wr_pkg::axi_id_t        st_rsp_axi_id,
    output logic                        st_rsp_code,
    input  logic                        st_rsp_ready
);

    localparam int ID_BITS = `ODMA_ENGINE_ID_BITS;

    localparam logic [ID_BITS-1:0] CMP_ID = ID_BITS'(`ODMA_CMP_ENGINE_ID);
    localparam logic [ID_BITS-1:0] MM_ID  = ID_BITS'(`ODMA_A2HMM_ENGINE_ID);
    localparam logic [ID_BITS-1:0] ST_ID  = ID_BITS'(`ODMA_A2HST_ENGINE_ID);

    logic [2:0] rsp_sel;

    // Engine match {st, mm, cmp} for a low ID field
    function automatic logic [2:0] engine_sel(input logic [ID_BITS-1:0] id_low);
        engine_sel = {id_low == ST_ID, id_low == MM_ID, id_low == CMP_ID};
    endfunction

    assign rsp_sel = engine_sel(lcl_wr_rsp_axi_id[ID_BITS-1:0]);

    // Unmatched IDs reach no engine
    assign cmp_rsp_valid  = rsp_sel[0] & lcl_wr_rsp_valid;
    assign cmp_rsp_axi_id = rsp_sel[0] ? lcl_wr_rsp_axi_id : '0;
    assign cmp_rsp_code   = rsp_sel[0] & lcl_wr_rsp_code;
    assign mm_rsp_valid   = rsp_sel[1] & lcl_wr_rsp_valid;
    assign mm_rsp_axi_id  = rsp_sel[1] ? lcl_wr_rsp_axi_id : '0;
    assign mm_rsp_code    = rsp_sel[1] & lcl_wr_rsp_code;
    assign st_rsp_valid   = rsp_sel[2] & lcl_wr_rsp_valid;
    assign st_rsp_axi_id  = rsp_sel[2] ? lcl_wr_rsp_axi_id : '0;
    assign st_rsp_code    = rsp_sel[2] & lcl_wr_rsp_code;

    // Each ID value takes the ready of the engine its low field names
    always_comb begin
        for (int i = 0; i < $bits(lcl_wr_rsp_ready); i++) begin
            lcl_wr_rsp_ready[i] =
                |(engine_sel(ID_BITS'(i)) & {st_rsp_ready, mm_rsp_ready, cmp_rsp_ready});
        end
    end

    always_comb begin
        a_rsp_onehot: assert final ($onehot0({st_rsp_valid, mm_rsp_valid, cmp_rsp_valid}));
    end

endmodule

// ==== rtl/odma_lcl_wr_arbiter.sv ====
// Local write port arbiter
`timescale 1ns/1ps

module odma_lcl_wr_arbiter (
    input  logic                        clk,
    input  logic                        resetn,
    // Shared write channel
    output logic                        lcl_wr_valid,
    output odma_wr_pkg::ea_t            lcl_wr_ea,
    output odma_wr_pkg::axi_id_t        lcl_wr_axi_id,
    output odma_wr_pkg::be_t            lcl_wr_be,
    output logic                        lcl_wr_first,
    output logic                        lcl_wr_last,
    output odma_wr_pkg::data_t          lcl_wr_data,
    input  logic                        lcl_wr_ready,
    input  logic                        lcl_wr_rsp_valid,
    input  odma_wr_pkg::axi_id_t        lcl_wr_rsp_axi_id,
    input  logic                        lcl_wr_rsp_code,
    output odma_wr_pkg::rsp_ready_vec_t lcl_wr_rsp_ready,
    // Compare engine
    input  logic                        cmp_lcl_wr_valid,
    input  odma_wr_pkg::ea_t            cmp_lcl_wr_ea,
    input  odma_wr_pkg::axi_id_t        cmp_lcl_wr_axi_id,
    input  odma_wr_pkg::be_t            cmp_lcl_wr_be,
    input  logic                        cmp_lcl_wr_first,
    input  logic                        cmp_lcl_wr_last,
    input  odma_wr_pkg::data_t          cmp_lcl_wr_data,
    output logic                        cmp_lcl_wr_ready,
    output logic                        cmp_lcl_wr_rsp_valid,
    output odma_wr_pkg::axi_id_t        cmp_lcl_wr_rsp_axi_id,
    output logic                        cmp_lcl_wr_rsp_code,
    input  logic                        cmp_lcl_wr_rsp_ready,
    // Memory-mapped host engine
    input  logic                        mm_lcl_wr_valid,
    input  odma_wr_pkg::ea_t            mm_lcl_wr_ea,
    input  odma_wr_pkg::axi_id_t        mm_lcl_wr_axi_id,
    input  odma_wr_pkg::be_t            mm_lcl_wr_be,
    input  logic                        mm_lcl_wr_first,
    input  logic                        mm_lcl_wr_last,
    input  odma_wr_pkg::data_t          mm_lcl_wr_data,
    output logic                        mm_lcl_wr_ready,
    output logic                        mm_lcl_wr_rsp_valid,
    output odma_wr_pkg::axi_id_t        mm_lcl_wr_rsp_axi_id,
    output logic                        mm_lcl_wr_rsp_code,
    input  logic                        mm_lcl_wr_rsp_ready,
    // Streaming host engine
    input  logic                        st_lcl_wr_valid,
    input  odma_wr_pkg::ea_t            st_lcl_wr_ea,
    input  odma_wr_pkg::axi_id_t        st_lcl_wr_axi_id,
    input  odma_wr_pkg::be_t            st_lcl_wr_be,
    input  logic                        st_lcl_wr_first,
    input  logic                        st_lcl_wr_last,
    input  odma_wr_pkg::data_t          st_lcl_wr_data,
    output logic                        st_lcl_wr_ready,
    output logic                        st_lcl_wr_rsp_valid,
    output odma_wr_pkg::axi_id_t        st_lcl_wr_rsp_axi_id,
    output logic                        st_lcl_wr_rsp_code,
    input  logic                        st_lcl_wr_rsp_ready
);

    odma_wr_pkg::grant_state_t grant;

    odma_wr_grant_arbiter i_grant (
        .clk          (clk),
        .resetn       (resetn),
        .cmp_valid    (cmp_lcl_wr_valid),
        .mm_valid     (mm_lcl_wr_valid),
        .st_valid     (st_lcl_wr_valid),
        .cmp_last     (cmp_lcl_wr_last),
        .mm_last      (mm_lcl_wr_last),
        .st_last      (st_lcl_wr_last),
        .lcl_wr_ready (lcl_wr_ready),
        .grant        (grant)
    );

    odma_wr_req_mux i_req_mux (
        .grant         (grant),
        .cmp_wr_valid  (cmp_lcl_wr_valid),
        .cmp_wr_first  (cmp_lcl_wr_first),
        .cmp_wr_last   (cmp_lcl_wr_last),
        .cmp_wr_ea     (cmp_lcl_wr_ea),
        .cmp_wr_axi_id (cmp_lcl_wr_axi_id),
        .cmp_wr_be     (cmp_lcl_wr_be),
        .cmp_wr_data   (cmp_lcl_wr_data),
        .mm_wr_valid   (mm_lcl_wr_valid),
        .mm_wr_first   (mm_lcl_wr_first),
        .mm_wr_last    (mm_lcl_wr_last),
        .mm_wr_ea      (mm_lcl_wr_ea),
        .mm_wr_axi_id  (mm_lcl_wr_axi_id),
        .mm_wr_be      (mm_lcl_wr_be),
        .mm_wr_data    (mm_lcl_wr_data),
        .st_wr_valid   (st_lcl_wr_valid),
        .st_wr_first   (st_lcl_wr_first),
        .st_wr_last    (st_lcl_wr_last),
        .st_wr_ea      (st_lcl_wr_ea),
        .st_wr_axi_id  (st_lcl_wr_axi_id),
        .st_wr_be      (st_lcl_wr_be),
        .st_wr_data    (st_lcl_wr_data),
        .lcl_wr_ready  (lcl_wr_ready),
        .lcl_wr_valid  (lcl_wr_valid),
        .lcl_wr_ea     (lcl_wr_ea),
        .lcl_wr_axi_id (lcl_wr_axi_id),
        .lcl_wr_be     (lcl_wr_be),
        .lcl_wr_first  (lcl_wr_first),
        .lcl_wr_last   (lcl_wr_last),
        .lcl_wr_data   (lcl_wr_data),
        .cmp_wr_ready  (cmp_lcl_wr_ready),
        .mm_wr_ready   (mm_lcl_wr_ready),
        .st_wr_ready   (st_lcl_wr_ready)
    );

    odma_wr_rsp_dispatch i_rsp_dispatch (
        .lcl_wr_rsp_valid  (lcl_wr_rsp_valid),
        .lcl_wr_rsp_axi_id (lcl_wr_rsp_axi_id),
        .lcl_wr_rsp_code   (lcl_wr_rsp_code),
        .lcl_wr_rsp_ready  (lcl_wr_rsp_ready),
        .cmp_rsp_valid     (cmp_lcl_wr_rsp_valid),
        .cmp_rsp_axi_id    (cmp_lcl_wr_rsp_axi_id),
        .cmp_rsp_code      (cmp_lcl_wr_rsp_code),
        .cmp_rsp_ready     (cmp_lcl_wr_rsp_ready),
        .mm_rsp_valid      (mm_lcl_wr_rsp_valid),
        .mm_rsp_axi_id     (mm_lcl_wr_rsp_axi_id),
        .mm_rsp_code       (mm_lcl_wr_rsp_code),
        .mm_rsp_ready      (mm_lcl_wr_rsp_ready),
        .st_rsp_valid      (st_lcl_wr_rsp_valid),
        .st_rsp_axi_id     (st_lcl_wr_rsp_axi_id),
        .st_rsp_code       (st_lcl_wr_rsp_code),
        .st_rsp_ready      (st_lcl_wr_rsp_ready)
    );

endmodule

// ==== bench/tb_odma_lcl_wr_arbiter.sv ====
// Local write arbiter testbench
`timescale 1ns/1ps
`include "odma_defines.svh"

module tb_odma_lcl_wr_arbiter;

    localparam int AW = `ODMA_AXI_ID_WIDTH;
    // Reset, 27 packets of up to 5 beats, idle gaps and 64 response cycles
    localparam int TEST_CYCLES = 8 + 27 * 5 + 20 + 64;

    logic clk = 1'b0;
    logic resetn, lcl_wr_ready, lcl_wr_rsp_valid, lcl_wr_rsp_code;
    logic lcl_wr_valid, lcl_wr_first, lcl_wr_last;
    odma_wr_pkg::ea_t lcl_wr_ea, cmp_lcl_wr_ea, mm_lcl_wr_ea, st_lcl_wr_ea;
    odma_wr_pkg::axi_id_t lcl_wr_axi_id, cmp_lcl_wr_axi_id, mm_lcl_wr_axi_id, st_lcl_wr_axi_id;
    odma_wr_pkg::axi_id_t lcl_wr_rsp_axi_id;
    odma_wr_pkg::axi_id_t cmp_lcl_wr_rsp_axi_id, mm_lcl_wr_rsp_axi_id, st_lcl_wr_rsp_axi_id;
    odma_wr_pkg::be_t lcl_wr_be, cmp_lcl_wr_be, mm_lcl_wr_be, st_lcl_wr_be;
    odma_wr_pkg::data_t lcl_wr_data, cmp_lcl_wr_data, mm_lcl_wr_data, st_lcl_wr_data;
    odma_wr_pkg::rsp_ready_vec_t lcl_wr_rsp_ready;
    logic cmp_lcl_wr_valid, mm_lcl_wr_valid, st_lcl_wr_valid;
    logic cmp_lcl_wr_first, mm_lcl_wr_first, st_lcl_wr_first;
    logic cmp_lcl_wr_last, mm_lcl_wr_last, st_lcl_wr_last;
    logic cmp_lcl_wr_ready, mm_lcl_wr_ready, st_lcl_wr_ready;
    logic cmp_lcl_wr_rsp_valid, mm_lcl_wr_rsp_valid, st_lcl_wr_rsp_valid;
    logic cmp_lcl_wr_rsp_code, mm_lcl_wr_rsp_code, st_lcl_wr_rsp_code;
    logic cmp_lcl_wr_rsp_ready, mm_lcl_wr_rsp_ready, st_lcl_wr_rsp_ready;

    // Engine stimulus, index 0 is cmp, 1 is mm, 2 is st
    logic [2:0] eng_valid, eng_first, eng_last, eng_rsp_ready;
    odma_wr_pkg::ea_t [2:0] eng_ea;
    odma_wr_pkg::axi_id_t [2:0] eng_id;
    odma_wr_pkg::be_t [2:0] eng_be;
    odma_wr_pkg::data_t [2:0] eng_data;
    int pkts_left[3];
    int beats_left[3];
    int model_owner;
    int error_count;
    int test_count;
    logic model_linger, stall_on, rsp_active;
    logic [31:0] rng_state = 32'h4808;

    assign {st_lcl_wr_valid, mm_lcl_wr_valid, cmp_lcl_wr_valid} = eng_valid;
    assign {st_lcl_wr_first, mm_lcl_wr_first, cmp_lcl_wr_first} = eng_first;
    assign {st_lcl_wr_last, mm_lcl_wr_last, cmp_lcl_wr_last} = eng_last;
    assign {st_lcl_wr_ea, mm_lcl_wr_ea, cmp_lcl_wr_ea} = eng_ea;
    assign {st_lcl_wr_axi_id, mm_lcl_wr_axi_id, cmp_lcl_wr_axi_id} = eng_id;
    assign {st_lcl_wr_be, mm_lcl_wr_be, cmp_lcl_wr_be} = eng_be;
    assign {st_lcl_wr_data, mm_lcl_wr_data, cmp_lcl_wr_data} = eng_data;
    assign {st_lcl_wr_rsp_ready, mm_lcl_wr_rsp_ready, cmp_lcl_wr_rsp_ready} = eng_rsp_ready;

    wire [2:0] eng_ready = {st_lcl_wr_ready, mm_lcl_wr_ready, cmp_lcl_wr_ready};
    wire [2:0] eng_rsp_valid = {st_lcl_wr_rsp_valid, mm_lcl_wr_rsp_valid, cmp_lcl_wr_rsp_valid};
    wire [2:0] eng_rsp_code = {st_lcl_wr_rsp_code, mm_lcl_wr_rsp_code, cmp_lcl_wr_rsp_code};
    wire [3*AW-1:0] eng_rsp_id = {st_lcl_wr_rsp_axi_id, mm_lcl_wr_rsp_axi_id,
                                  cmp_lcl_wr_rsp_axi_id};

    odma_lcl_wr_arbiter i_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic odma_wr_pkg::data_t random_wide();
        odma_wr_pkg::data_t w;
        for (int i = 0; i < $bits(w) / 32; i++)
            w[i*32 +: 32] = next_random();
        return w;
    endfunction

    // First valid engine in the order cmp, mm, st, leaving out one index
    function automatic int first_valid(input logic [2:0] v, input int skip);
        for (int e = 0; e < 3; e++)
            if (v[e] && e != skip)
                return e;
        return -1;
    endfunction

    // One-hot engine {st, mm, cmp} named by a low ID field
    function automatic logic [2:0] id_owner(input logic [`ODMA_ENGINE_ID_BITS-1:0] low);
        if (low == `ODMA_CMP_ENGINE_ID)
            return 3'b001;
        if (low == `ODMA_A2HMM_ENGINE_ID)
            return 3'b010;
        if (low == `ODMA_A2HST_ENGINE_ID)
            return 3'b100;
        return 3'b000;
    endfunction

    // Expected {valid, code, axi_id} of all three engine response outputs
    function automatic logic [3*AW+5:0] routed_rsp(input logic valid, input logic code,
                                                   input odma_wr_pkg::axi_id_t id);
        logic [2:0] sel;
        sel = id_owner(id[`ODMA_ENGINE_ID_BITS-1:0]);
        return {sel & {3{valid}}, sel & {3{code}},
                {3{id}} & {{AW{sel[2]}}, {AW{sel[1]}}, {AW{sel[0]}}}};
    endfunction

    function automatic odma_wr_pkg::rsp_ready_vec_t expected_rsp_ready(input logic [2:0] rdy);
        odma_wr_pkg::rsp_ready_vec_t v;
        for (int i = 0; i < $bits(v); i++)
            v[i] = |(id_owner(i[`ODMA_ENGINE_ID_BITS-1:0]) & rdy);
        return v;
    endfunction

    task automatic flag_mismatch(input string what);
        error_count++;
        $display("CHECK FAILED at %0t: %s", $time, what);
    endtask

    task automatic close_test(input string name);
        test_count++;
        $display("Test %0d (%s) finished, %0d errors so far", test_count, name, error_count);
    endtask

    task automatic wait_idle();
        do
            @(posedge clk);
        while (pkts_left.sum() != 0 || beats_left.sum() != 0);
    endtask

    // Reference grant, -1 while nothing is granted
    always @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            model_owner <= -1;
            model_linger <= 1'b0;
        end else if (model_owner < 0) begin
            model_owner <= first_valid(eng_valid, -1);
        end else if (eng_valid[model_owner] && eng_last[model_owner] && lcl_wr_ready) begin
            // Packet end goes to one of the other two, or lingers
            if (first_valid(eng_valid, model_owner) >= 0)
                model_owner <= first_valid(eng_valid, model_owner);
            model_linger <= first_valid(eng_valid, model_owner) < 0;
        end else if (model_linger && eng_valid != 3'b000) begin
            // Owner keeps it while valid, else cmp, mm, st
            if (!eng_valid[model_owner])
                model_owner <= first_valid(eng_valid, -1);
            model_linger <= 1'b0;
        end
    end

    // Packets, back-pressure and responses
    always @(posedge clk) begin
        logic [2:0] xfer;
        logic new_beat;
        logic [31:0] r;
        odma_wr_pkg::data_t wide;
        xfer = eng_valid & eng_ready;
        #1;
        for (int e = 0; e < 3; e++) begin
            new_beat = xfer[e] && beats_left[e] > 1;
            if (xfer[e]) begin
                beats_left[e]--;
                eng_first[e] = 1'b0;
            end
            if (beats_left[e] == 0 && pkts_left[e] > 0) begin
                pkts_left[e]--;
                beats_left[e] = 1 + next_random() % 5;
                eng_first[e] = 1'b1;
                new_beat = 1'b1;
            end
            if (new_beat) begin
                eng_data[e] = random_wide();
                wide = random_wide();
                eng_ea[e] = wide[`ODMA_EA_WIDTH-1:0];
                eng_be[e] = wide[`ODMA_EA_WIDTH +: `ODMA_BE_WIDTH];
                eng_id[e] = wide[$bits(wide)-1 -: AW];
            end
            eng_valid[e] = beats_left[e] != 0;
            eng_last[e] = beats_left[e] == 1;
        end
        lcl_wr_ready = !stall_on || next_random() % 4 != 0;
        if (rsp_active) begin
            r = next_random();
            lcl_wr_rsp_valid = r[0];
            lcl_wr_rsp_code = r[1];
            lcl_wr_rsp_axi_id = r[4 +: AW];
            eng_rsp_ready = r[12 +: 3];
        end
    end

    a_engine_ready: assert property (@(posedge clk) disable iff (!resetn)
        eng_ready == ((model_owner >= 0 && lcl_wr_ready) ? 3'(1 << model_owner) : 3'b000))
        else flag_mismatch("engine readies do not match the expected grant");

    a_shared_beat: assert property (@(posedge clk) disable iff (!resetn)
        {lcl_wr_valid, lcl_wr_first, lcl_wr_last, lcl_wr_axi_id, lcl_wr_ea, lcl_wr_be,
         lcl_wr_data}
            == ((model_owner < 0) ? '0 : {eng_valid[model_owner], eng_first[model_owner],
                eng_last[model_owner], eng_id[model_owner], eng_ea[model_owner],
                eng_be[model_owner], eng_data[model_owner]}))
        else flag_mismatch("shared channel beat differs from the granted engine");

    a_rsp_route: assert property (@(posedge clk)
        {eng_rsp_valid, eng_rsp_code, eng_rsp_id}
            == routed_rsp(lcl_wr_rsp_valid, lcl_wr_rsp_code, lcl_wr_rsp_axi_id))
        else flag_mismatch("engine response outputs do not follow the ID routing");

    a_rsp_ready: assert property (@(posedge clk)
        lcl_wr_rsp_ready == expected_rsp_ready(eng_rsp_ready))
        else flag_mismatch("response ready vector does not match the ID map");

    initial begin
        #(TEST_CYCLES * 4 * 4);
        $display("Run timed out after %0d cycles with tests unfinished", TEST_CYCLES * 4);
        $display("Checks failed");
        $finish;
    end

    initial begin
        resetn = 1'b0;
        lcl_wr_ready = 1'b0;
        lcl_wr_rsp_valid = 1'b0;
        lcl_wr_rsp_code = 1'b0;
        lcl_wr_rsp_axi_id = '0;
        eng_valid = '0;
        eng_first = '0;
        eng_last = '0;
        eng_rsp_ready = '0;
        eng_ea = '0;
        eng_id = '0;
        eng_be = '0;
        eng_data = '0;
        pkts_left = '{default: 0};
        beats_left = '{default: 0};
        error_count = 0;
        test_count = 0;
        stall_on = 1'b0;
        rsp_active = 1'b0;
        repeat (8) @(posedge clk);
        #1 resetn = 1'b1;
        @(posedge clk);

        for (int e = 0; e < 3; e++) begin
            pkts_left[e] = 3;
            wait_idle();
        end
        close_test("single engine");

        pkts_left = '{4, 4, 4};
        wait_idle();
        close_test("rotation");

        // cmp shows up while an st packet is still running
        stall_on = 1'b1;
        pkts_left[2] = 1;
        repeat (1) @(posedge clk);
        pkts_left[0] = 1;
        wait_idle();
        close_test("packet lock");

        pkts_left[1] = 1;
        wait_idle();
        repeat (3) @(posedge clk);
        pkts_left[2] = 1;
        wait_idle();
        repeat (3) @(posedge clk);
        // Lingering owner st should win over cmp
        pkts_left[0] = 1;
        pkts_left[2] = 1;
        wait_idle();
        close_test("linger");

        rsp_active = 1'b1;
        repeat (64) @(posedge clk);
        close_test("response routing");

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/odma_wr_pkg.sv
rtl/odma_wr_grant_arbiter.sv
rtl/odma_wr_req_mux.sv
rtl/odma_wr_rsp_dispatch.sv
rtl/odma_lcl_wr_arbiter.sv
bench/tb_odma_lcl_wr_arbiter.sv

// ==== Bender.yml ====
package:
  name: odma_lcl_wr_arbiter

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/odma_wr_pkg.sv
      - rtl/odma_wr_grant_arbiter.sv
      - rtl/odma_wr_req_mux.sv
      - rtl/odma_wr_rsp_dispatch.sv
      - rtl/odma_lcl_wr_arbiter.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_odma_lcl_wr_arbiter.sv
